// File: hw/saturn_dec_pkg.sv
/* shared widths and codes for the nibble-serial decoder
   alu codes are 5 bits wide so that more operations can be added later
   ALU_OP_NONE must stay 0, since reset and control-only instructions rely on it */
package saturn_dec_pkg;

  // one opcode nibble
  localparam int NIBBLE_W = 4;

  // default program address width, 5 nibbles
  localparam int DEF_ADDR_W = 20;

  // longest immediate, the 3Fxxxx... load
  localparam int DEF_MAX_IMM = 16;

  // opcode or immediate nibble
  typedef logic [NIBBLE_W-1:0] nibble_t;

  // alu operation handed to the execute stage
  typedef enum logic [4:0] {
    // no alu work, also the reset value
    ALU_OP_NONE     = 5'd0,
    // register clear, 08
    ALU_OP_ZERO     = 5'd1,
    // plain move, 06/07/09/0A and loads
    ALU_OP_COPY     = 5'd2,
    // swap, 0B
    ALU_OP_EXCH     = 5'd3,
    // P=P+1
    ALU_OP_INC      = 5'd4,
    // P=P-1
    ALU_OP_DEC      = 5'd5,
    // 2-nibble relative jump, GOC/GONC
    ALU_OP_JMP_REL2 = 5'd6,
    // 3-nibble relative jump, GOTO/GOSUB
    ALU_OP_JMP_REL3 = 5'd7
  } alu_op_t;

  // the remaining codes are reserved for the
  // field-based arithmetic groups (Ax, Bx, Cx...)
  // which are decoded as errors for now

endpackage

// File: hw/opcode_classifier.sv
`timescale 1ns/1ns
/* stage 1: one nibble per clock while i_en_dec is high and i_stalled low
   control fields are valid together with o_last and change on the next first nibble
   only groups 0x, 2x, 3x, 4x-7x are decoded, anything else closes as a decode error */
module opcode_classifier #(
  parameter int ADDR_W = saturn_dec_pkg::DEF_ADDR_W
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_en_dec,
  input  logic                    i_stalled,
  input  saturn_dec_pkg::nibble_t i_nibble,
  input  logic [ADDR_W-1:0]       i_pc,
  output logic                    o_valid,
  output saturn_dec_pkg::nibble_t o_nibble,
  output logic                    o_first,
  output logic [ADDR_W-1:0]       o_addr,
  output logic                    o_imm,
  output logic                    o_last,
  output saturn_dec_pkg::alu_op_t o_alu_op,
  output logic                    o_ins_alu_op,
  output logic                    o_rtn,
  output logic                    o_push,
  output logic                    o_pop,
  output logic                    o_set_xm,
  output logic                    o_set_carry,
  output logic                    o_carry_val,
  output logic                    o_en_intr,
  output logic                    o_test_carry,
  output logic                    o_set_mode,
  output logic                    o_mode_dec,
  output logic                    o_dec_error
);
  import saturn_dec_pkg::*;

  // framing state, where the next nibble falls
  typedef enum logic [2:0] {
    ST_FIRST,
    ST_B0X,
    ST_B2X,
    ST_B3X,
    ST_IMM
  } frame_t;

  frame_t              state;
  frame_t              state_nxt;
  // immediates still to come, minus one
  logic [NIBBLE_W-1:0] imm_left;
  logic [NIBBLE_W-1:0] imm_left_nxt;
  logic                accept;
  logic                is_imm;
  logic                is_last;

  // nibble taken at this edge
  assign accept = i_en_dec && !i_stalled;

  // framing decisions for the nibble on i_nibble
  always_comb begin
    state_nxt    = state;
    imm_left_nxt = imm_left;
    is_imm       = 1'b0;
    is_last      = 1'b0;
    case (state)
      ST_FIRST: begin
        case (i_nibble)
          4'h0: state_nxt = ST_B0X;
          4'h2: state_nxt = ST_B2X;
          4'h3: state_nxt = ST_B3X;
          4'h4, 4'h5: begin
            // GOC/GONC offset, 2 nibbles
            state_nxt    = ST_IMM;
            imm_left_nxt = NIBBLE_W'(1);
          end
          4'h6, 4'h7: begin
            // GOTO/GOSUB offset, 3 nibbles
            state_nxt    = ST_IMM;
            imm_left_nxt = NIBBLE_W'(2);
          end
          // 1x, 8x-Fx are one-nibble errors
          default: is_last = 1'b1;
        endcase
      end
      ST_B0X: begin
        is_last   = 1'b1;
        state_nxt = ST_FIRST;
      end
      ST_B2X: begin
        // the P value is the single immediate
        is_imm    = 1'b1;
        is_last   = 1'b1;
        state_nxt = ST_FIRST;
      end
      ST_B3X: begin
        // count nibble, n+1 immediates follow
        state_nxt    = ST_IMM;
        imm_left_nxt = i_nibble;
      end
      ST_IMM: begin
        is_imm = 1'b1;
        if (imm_left == '0) begin
          is_last   = 1'b1;
          state_nxt = ST_FIRST;
        end else begin
          imm_left_nxt = imm_left - NIBBLE_W'(1);
        end
      end
      default: state_nxt = ST_FIRST;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state    <= ST_FIRST;
      imm_left <= '0;
      o_valid  <= 1'b0;
    end else begin
      o_valid <= accept;
      // framing freezes while nothing is accepted
      if (accept) begin
        state    <= state_nxt;
        imm_left <= imm_left_nxt;
      end
    end
  end

  // record payload, qualified by o_valid
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_nibble <= i_nibble;
      o_first  <= (state == ST_FIRST);
      o_imm    <= is_imm;
      o_last   <= is_last;
      if (state == ST_FIRST) begin
        o_addr <= i_pc;
      end
    end
  end

  // control fields from the first two nibbles
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_alu_op     <= ALU_OP_NONE;
      o_ins_alu_op <= 1'b0;
      o_rtn        <= 1'b0;
      o_push       <= 1'b0;
      o_pop        <= 1'b0;
      o_set_xm     <= 1'b0;
      o_set_carry  <= 1'b0;
      o_carry_val  <= 1'b0;
      o_en_intr    <= 1'b0;
      o_test_carry <= 1'b0;
      o_set_mode   <= 1'b0;
      o_mode_dec   <= 1'b0;
      o_dec_error  <= 1'b0;
    end else if (accept && state == ST_FIRST) begin
      // clear the previous instruction, then set by group
      o_alu_op     <= ALU_OP_NONE;
      o_ins_alu_op <= 1'b0;
      o_rtn        <= 1'b0;
      o_push       <= 1'b0;
      o_pop        <= 1'b0;
      o_set_xm     <= 1'b0;
      o_set_carry  <= 1'b0;
      o_carry_val  <= 1'b0;
      o_en_intr    <= 1'b0;
      o_test_carry <= 1'b0;
      o_set_mode   <= 1'b0;
      o_mode_dec   <= 1'b0;
      o_dec_error  <= 1'b0;
      case (i_nibble)
        4'h0: ;
        4'h2, 4'h3: begin
          // P=n and LC(n+1) are copies of the immediate
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_COPY;
        end
        4'h4, 4'h5: begin
          // 4 jumps on carry set, 5 on carry clear
          o_alu_op     <= ALU_OP_JMP_REL2;
          o_test_carry <= 1'b1;
          o_carry_val  <= !i_nibble[0];
        end
        4'h6, 4'h7: begin
          // GOSUB pushes the return address
          o_alu_op <= ALU_OP_JMP_REL3;
          o_push   <= i_nibble[0];
        end
        default: o_dec_error <= 1'b1;
      endcase
    end else if (accept && state == ST_B0X) begin
      case (i_nibble)
        4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
          // RTNSXM, RTN, RTNSC, RTNCC, RTI
          o_rtn       <= 1'b1;
          o_pop       <= 1'b1;
          o_set_xm    <= (i_nibble == 4'h0);
          o_set_carry <= !i_nibble[3] && i_nibble[1];
          o_carry_val <= i_nibble[1] && !i_nibble[0];
          o_en_intr   <= i_nibble[3];
        end
        4'h4, 4'h5: begin
          // SETHEX / SETDEC
          o_set_mode <= 1'b1;
          o_mode_dec <= i_nibble[0];
        end
        4'h6, 4'h7: begin
          // RSTK=C pushes, C=RSTK pops
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_COPY;
          o_push       <= !i_nibble[0];
          o_pop        <= i_nibble[0];
        end
        4'h8: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_ZERO;
        end
        4'h9, 4'hA: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_COPY;
        end
        4'hB: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_EXCH;
        end
        4'hC, 4'hD: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= i_nibble[0] ? ALU_OP_DEC : ALU_OP_INC;
        end
        // 0E logic ops are not decoded
        default: o_dec_error <= 1'b1;
      endcase
    end
  end

endmodule

// File: hw/instruction_assembler.sv
`timescale 1ns/1ns
/* stage 2: takes every stage-1 record, there is no back-pressure
   immediates land low position first, o_mem_load is cleared on each first nibble */
module instruction_assembler #(
  parameter int ADDR_W  = saturn_dec_pkg::DEF_ADDR_W,
  parameter int MAX_IMM = saturn_dec_pkg::DEF_MAX_IMM
) (
  input  logic                                           i_clk,
  input  logic                                           i_reset,
  input  logic                                           i_valid,
  input  saturn_dec_pkg::nibble_t                        i_nibble,
  input  logic                                           i_first,
  input  logic [ADDR_W-1:0]                              i_addr,
  input  logic                                           i_imm,
  input  logic                                           i_last,
  input  saturn_dec_pkg::alu_op_t                        i_alu_op,
  input  logic                                           i_ins_alu_op,
  input  logic                                           i_rtn,
  input  logic                                           i_push,
  input  logic                                           i_pop,
  input  logic                                           i_set_xm,
  input  logic                                           i_set_carry,
  input  logic                                           i_carry_val,
  input  logic                                           i_en_intr,
  input  logic                                           i_test_carry,
  input  logic                                           i_set_mode,
  input  logic                                           i_mode_dec,
  input  logic                                           i_dec_error,
  output logic                                           o_ins_decoded,
  output logic [ADDR_W-1:0]                              o_ins_addr,
  output saturn_dec_pkg::nibble_t                        o_imm_value,
  output logic [MAX_IMM*saturn_dec_pkg::NIBBLE_W-1:0]    o_mem_load,
  output logic [$clog2(MAX_IMM+1)-1:0]                   o_mem_pos,
  output saturn_dec_pkg::alu_op_t                        o_alu_op,
  output logic                                           o_ins_alu_op,
  output logic                                           o_ins_rtn,
  output logic                                           o_push,
  output logic                                           o_pop,
  output logic                                           o_set_xm,
  output logic                                           o_set_carry,
  output logic                                           o_carry_val,
  output logic                                           o_en_intr,
  output logic                                           o_test_carry,
  output logic                                           o_ins_set_mode,
  output logic                                           o_mode_dec,
  output logic                                           o_dec_error
);
  import saturn_dec_pkg::*;

  localparam int POS_W = $clog2(MAX_IMM + 1);

  // start address of the instruction in flight
  logic [ADDR_W-1:0] start_addr;
  // write slot, restarts on a first record
  logic [POS_W-1:0]  wr_pos;

  assign wr_pos = i_first ? '0 : o_mem_pos;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ins_decoded  <= 1'b0;
      o_mem_pos      <= '0;
      o_alu_op       <= ALU_OP_NONE;
      o_ins_alu_op   <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_en_intr      <= 1'b0;
      o_test_carry   <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
      o_dec_error    <= 1'b0;
    end else begin
      // one-cycle pulse per closing record
      o_ins_decoded <= i_valid && i_last;
      if (i_valid) begin
        o_mem_pos <= wr_pos + POS_W'(i_imm);
      end
      // fields hold until the next instruction closes
      if (i_valid && i_last) begin
        o_alu_op       <= i_alu_op;
        o_ins_alu_op   <= i_ins_alu_op;
        o_ins_rtn      <= i_rtn;
        o_push         <= i_push;
        o_pop          <= i_pop;
        o_set_xm       <= i_set_xm;
        o_set_carry    <= i_set_carry;
        o_carry_val    <= i_carry_val;
        o_en_intr      <= i_en_intr;
        o_test_carry   <= i_test_carry;
        o_ins_set_mode <= i_set_mode;
        o_mode_dec     <= i_mode_dec;
        o_dec_error    <= i_dec_error;
      end
    end
  end

  // immediate and address payload
  always_ff @(posedge i_clk) begin
    if (i_valid && i_first) begin
      start_addr <= i_addr;
      o_mem_load <= '0;
    end
    if (i_valid && i_imm) begin
      o_mem_load[wr_pos*NIBBLE_W +: NIBBLE_W] <= i_nibble;
      o_imm_value                             <= i_nibble;
    end
    // one-nibble instructions close on their first record
    if (i_valid && i_last) begin
      o_ins_addr <= i_first ? i_addr : start_addr;
    end
  end

endmodule

// File: hw/saturn_decoder.sv
`timescale 1ns/1ns
/* two-stage nibble decoder, results appear two cycles after the last nibble
   the PC is owned outside, i_pc must hold the address of the nibble on i_nibble */
module saturn_decoder #(
  parameter int ADDR_W  = saturn_dec_pkg::DEF_ADDR_W,
  parameter int MAX_IMM = saturn_dec_pkg::DEF_MAX_IMM
) (
  input  logic                                        i_clk,
  input  logic                                        i_reset,
  input  logic                                        i_en_dec,
  input  logic                                        i_stalled,
  input  saturn_dec_pkg::nibble_t                     i_nibble,
  input  logic [ADDR_W-1:0]                           i_pc,
  output logic                                        o_ins_decoded,
  output logic [ADDR_W-1:0]                           o_ins_addr,
  output saturn_dec_pkg::nibble_t                     o_imm_value,
  output logic [MAX_IMM*saturn_dec_pkg::NIBBLE_W-1:0] o_mem_load,
  output logic [$clog2(MAX_IMM+1)-1:0]                o_mem_pos,
  output saturn_dec_pkg::alu_op_t                     o_alu_op,
  output logic                                        o_ins_alu_op,
  output logic                                        o_ins_rtn,
  output logic                                        o_push,
  output logic                                        o_pop,
  output logic                                        o_set_xm,
  output logic                                        o_set_carry,
  output logic                                        o_carry_val,
  output logic                                        o_en_intr,
  output logic                                        o_test_carry,
  output logic                                        o_ins_set_mode,
  output logic                                        o_mode_dec,
  output logic                                        o_dec_error
);
  import saturn_dec_pkg::*;

  // stage 1 record
  logic              s1_valid;
  nibble_t           s1_nibble;
  logic              s1_first;
  logic [ADDR_W-1:0] s1_addr;
  logic              s1_imm;
  logic              s1_last;
  // stage 1 control fields, valid with s1_last
  alu_op_t           s1_alu_op;
  logic              s1_ins_alu_op;
  logic              s1_rtn;
  logic              s1_push;
  logic              s1_pop;
  logic              s1_set_xm;
  logic              s1_set_carry;
  logic              s1_carry_val;
  logic              s1_en_intr;
  logic              s1_test_carry;
  logic              s1_set_mode;
  logic              s1_mode_dec;
  logic              s1_dec_error;

  opcode_classifier #(
    .ADDR_W(ADDR_W)
  ) opcode_classifier_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_en_dec     (i_en_dec),
    .i_stalled    (i_stalled),
    .i_nibble     (i_nibble),
    .i_pc         (i_pc),
    .o_valid      (s1_valid),
    .o_nibble     (s1_nibble),
    .o_first      (s1_first),
    .o_addr       (s1_addr),
    .o_imm        (s1_imm),
    .o_last       (s1_last),
    .o_alu_op     (s1_alu_op),
    .o_ins_alu_op (s1_ins_alu_op),
    .o_rtn        (s1_rtn),
    .o_push       (s1_push),
    .o_pop        (s1_pop),
    .o_set_xm     (s1_set_xm),
    .o_set_carry  (s1_set_carry),
    .o_carry_val  (s1_carry_val),
    .o_en_intr    (s1_en_intr),
    .o_test_carry (s1_test_carry),
    .o_set_mode   (s1_set_mode),
    .o_mode_dec   (s1_mode_dec),
    .o_dec_error  (s1_dec_error)
  );

  instruction_assembler #(
    .ADDR_W (ADDR_W),
    .MAX_IMM(MAX_IMM)
  ) instruction_assembler_inst (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_valid        (s1_valid),
    .i_nibble       (s1_nibble),
    .i_first        (s1_first),
    .i_addr         (s1_addr),
    .i_imm          (s1_imm),
    .i_last         (s1_last),
    .i_alu_op       (s1_alu_op),
    .i_ins_alu_op   (s1_ins_alu_op),
    .i_rtn          (s1_rtn),
    .i_push         (s1_push),
    .i_pop          (s1_pop),
    .i_set_xm       (s1_set_xm),
    .i_set_carry    (s1_set_carry),
    .i_carry_val    (s1_carry_val),
    .i_en_intr      (s1_en_intr),
    .i_test_carry   (s1_test_carry),
    .i_set_mode     (s1_set_mode),
    .i_mode_dec     (s1_mode_dec),
    .i_dec_error    (s1_dec_error),
    .o_ins_decoded  (o_ins_decoded),
    .o_ins_addr     (o_ins_addr),
    .o_imm_value    (o_imm_value),
    .o_mem_load     (o_mem_load),
    .o_mem_pos      (o_mem_pos),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_ins_rtn      (o_ins_rtn),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_en_intr      (o_en_intr),
    .o_test_carry   (o_test_carry),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_dec_error    (o_dec_error)
  );

endmodule

// File: dv/saturn_decoder_sva.sv
`timescale 1ns/1ns
/* concurrent checks on the decoder top level, attached by bind */
module saturn_decoder_sva #(
  parameter int MAX_IMM = saturn_dec_pkg::DEF_MAX_IMM
) (
  input logic                         i_clk,
  input logic                         i_reset,
  input logic                         o_ins_decoded,
  input logic                         o_push,
  input logic                         o_pop,
  input logic                         o_dec_error,
  input logic [$clog2(MAX_IMM+1)-1:0] o_mem_pos
);
  localparam int POS_W = $clog2(MAX_IMM + 1);

  // one pulse per instruction, a pulse right after another
  // can only close a one-nibble error
  a_single_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
    o_ins_decoded |=> !o_ins_decoded || o_dec_error)
    else $error("o_ins_decoded high in two consecutive cycles");

  // return stack moves one way at a time
  a_push_pop: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_push && o_pop))
    else $error("o_push and o_pop both high");

  a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> !o_ins_decoded)
    else $error("o_ins_decoded high during reset");

  // position counter stays inside o_mem_load
  a_pos_range: assert property (@(posedge i_clk) disable iff (i_reset)
    o_mem_pos <= POS_W'(MAX_IMM))
    else $error("o_mem_pos above MAX_IMM");

endmodule

bind saturn_decoder saturn_decoder_sva #(
  .MAX_IMM(MAX_IMM)
) saturn_decoder_sva_inst (
  .i_clk         (i_clk),
  .i_reset       (i_reset),
  .o_ins_decoded (o_ins_decoded),
  .o_push        (o_push),
  .o_pop         (o_pop),
  .o_dec_error   (o_dec_error),
  .o_mem_pos     (o_mem_pos)
);

// File: dv/saturn_decoder_tb.sv
`timescale 1ns/1ns
/* table-driven testbench for saturn_decoder, inputs change on the falling edge
   outputs are sampled on the falling edge, a decode is due two cycles after its last nibble */
module saturn_decoder_tb;
  import saturn_dec_pkg::*;

  localparam int ADDR_W  = DEF_ADDR_W;
  localparam int MAX_IMM = DEF_MAX_IMM;
  localparam int LOAD_W  = MAX_IMM * NIBBLE_W;
  localparam int POS_W   = $clog2(MAX_IMM + 1);

  // field bits, same order as got_flags
  localparam logic [11:0] F_IALU = 12'h001;
  localparam logic [11:0] F_RTN  = 12'h002;
  localparam logic [11:0] F_PUSH = 12'h004;
  localparam logic [11:0] F_POP  = 12'h008;
  localparam logic [11:0] F_XM   = 12'h010;
  localparam logic [11:0] F_SC   = 12'h020;
  localparam logic [11:0] F_CV   = 12'h040;
  localparam logic [11:0] F_EI   = 12'h080;
  localparam logic [11:0] F_TC   = 12'h100;
  localparam logic [11:0] F_SM   = 12'h200;
  localparam logic [11:0] F_MD   = 12'h400;
  localparam logic [11:0] F_ERR  = 12'h800;

  // one instruction in flight, waiting for its pulse
  typedef struct packed {
    int                idx;
    int                cycle;
    logic [LOAD_W-1:0] load;
    logic [ADDR_W-1:0] addr;
    nibble_t           imm;
  } expect_t;

  logic                i_clk;
  logic                i_reset;
  logic                i_en_dec;
  logic                i_stalled;
  nibble_t             i_nibble;
  logic [ADDR_W-1:0]   i_pc;
  logic                o_ins_decoded;
  logic [ADDR_W-1:0]   o_ins_addr;
  nibble_t             o_imm_value;
  logic [LOAD_W-1:0]   o_mem_load;
  logic [POS_W-1:0]    o_mem_pos;
  alu_op_t             o_alu_op;
  logic                o_ins_alu_op;
  logic                o_ins_rtn;
  logic                o_push;
  logic                o_pop;
  logic                o_set_xm;
  logic                o_set_carry;
  logic                o_carry_val;
  logic                o_en_intr;
  logic                o_test_carry;
  logic                o_ins_set_mode;
  logic                o_mode_dec;
  logic                o_dec_error;
  logic [11:0]         got_flags;

  // stimulus table, one row per instruction
  nibble_t             tbl_n0[$];
  nibble_t             tbl_n1[$];
  int                  tbl_fixed[$];
  int                  tbl_len[$];
  int                  tbl_nimm[$];
  alu_op_t             tbl_alu[$];
  logic [11:0]         tbl_flags[$];
  bit                  tbl_stall[$];

  expect_t             exp_q[$];
  expect_t             mon_ex;
  logic [31:0]         rng = 32'h943a_5c05;
  logic [ADDR_W-1:0]   pc;
  int                  cycle_cnt = 0;
  logic                check_en = 1'b0;
  int                  err_cnt = 0;
  int                  decode_cnt = 0;
  // fields must hold between pulses
  logic [11:0]         held_flags = '0;
  alu_op_t             held_alu = ALU_OP_NONE;

  assign got_flags = {o_dec_error, o_mode_dec, o_ins_set_mode, o_test_carry, o_en_intr,
                      o_carry_val, o_set_carry, o_set_xm, o_pop, o_push, o_ins_rtn,
                      o_ins_alu_op};

  saturn_decoder #(
    .ADDR_W (ADDR_W),
    .MAX_IMM(MAX_IMM)
  ) saturn_decoder_inst (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_dec       (i_en_dec),
    .i_stalled      (i_stalled),
    .i_nibble       (i_nibble),
    .i_pc           (i_pc),
    .o_ins_decoded  (o_ins_decoded),
    .o_ins_addr     (o_ins_addr),
    .o_imm_value    (o_imm_value),
    .o_mem_load     (o_mem_load),
    .o_mem_pos      (o_mem_pos),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_ins_rtn      (o_ins_rtn),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_en_intr      (o_en_intr),
    .o_test_carry   (o_test_carry),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_dec_error    (o_dec_error)
  );

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic add_entry(input nibble_t n0, input nibble_t n1, input int fixed,
                           input int len, input int nimm, input alu_op_t alu,
                           input logic [11:0] flags, input bit stall);
    tbl_n0.push_back(n0);
    tbl_n1.push_back(n1);
    tbl_fixed.push_back(fixed);
    tbl_len.push_back(len);
    tbl_nimm.push_back(nimm);
    tbl_alu.push_back(alu);
    tbl_flags.push_back(flags);
    tbl_stall.push_back(stall);
  endtask

  // n0, n1, fixed nibbles, length, immediates, alu op, fields, stall
  task automatic build_table();
    // returns, set-xm only for 00
    add_entry(4'h0, 4'h0, 2, 2, 0, ALU_OP_NONE, F_RTN | F_POP | F_XM, 1'b0);
    add_entry(4'h0, 4'h1, 2, 2, 0, ALU_OP_NONE, F_RTN | F_POP, 1'b0);
    add_entry(4'h0, 4'h2, 2, 2, 0, ALU_OP_NONE, F_RTN | F_POP | F_SC | F_CV, 1'b0);
    add_entry(4'h0, 4'h3, 2, 2, 0, ALU_OP_NONE, F_RTN | F_POP | F_SC, 1'b1);
    add_entry(4'h0, 4'hF, 2, 2, 0, ALU_OP_NONE, F_RTN | F_POP | F_EI, 1'b0);
    // hex / dec mode
    add_entry(4'h0, 4'h4, 2, 2, 0, ALU_OP_NONE, F_SM, 1'b0);
    add_entry(4'h0, 4'h5, 2, 2, 0, ALU_OP_NONE, F_SM | F_MD, 1'b0);
    // return stack copies
    add_entry(4'h0, 4'h6, 2, 2, 0, ALU_OP_COPY, F_IALU | F_PUSH, 1'b0);
    add_entry(4'h0, 4'h7, 2, 2, 0, ALU_OP_COPY, F_IALU | F_POP, 1'b1);
    // single nibble errors between normal instructions
    add_entry(4'h1, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'h0, 4'h8, 2, 2, 0, ALU_OP_ZERO, F_IALU, 1'b0);
    add_entry(4'h8, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'h0, 4'h9, 2, 2, 0, ALU_OP_COPY, F_IALU, 1'b0);
    add_entry(4'h0, 4'hA, 2, 2, 0, ALU_OP_COPY, F_IALU, 1'b0);
    add_entry(4'h9, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b1);
    add_entry(4'h0, 4'hB, 2, 2, 0, ALU_OP_EXCH, F_IALU, 1'b1);
    add_entry(4'h0, 4'hC, 2, 2, 0, ALU_OP_INC, F_IALU, 1'b0);
    add_entry(4'hA, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'h0, 4'hD, 2, 2, 0, ALU_OP_DEC, F_IALU, 1'b0);
    add_entry(4'h0, 4'hE, 2, 2, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'hB, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    // P=n, n is the only immediate
    add_entry(4'h2, 4'h9, 2, 2, 1, ALU_OP_COPY, F_IALU, 1'b0);
    // loads of 1 and 16 nibbles
    add_entry(4'h3, 4'h0, 2, 3, 1, ALU_OP_COPY, F_IALU, 1'b0);
    add_entry(4'h3, 4'hF, 2, 18, 16, ALU_OP_COPY, F_IALU, 1'b0);
    add_entry(4'hC, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'h3, 4'hF, 2, 18, 16, ALU_OP_COPY, F_IALU, 1'b1);
    // relative jumps, 4 on carry set and 5 on carry clear
    add_entry(4'h4, 4'h0, 1, 3, 2, ALU_OP_JMP_REL2, F_TC | F_CV, 1'b0);
    add_entry(4'h5, 4'h0, 1, 3, 2, ALU_OP_JMP_REL2, F_TC, 1'b1);
    add_entry(4'hD, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    // GOTO / GOSUB
    add_entry(4'h6, 4'h0, 1, 4, 3, ALU_OP_JMP_REL3, 12'h000, 1'b1);
    add_entry(4'h7, 4'h0, 1, 4, 3, ALU_OP_JMP_REL3, F_PUSH, 1'b0);
    add_entry(4'hE, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'hF, 4'h0, 1, 1, 0, ALU_OP_NONE, F_ERR, 1'b0);
    add_entry(4'h2, 4'h0, 2, 2, 1, ALU_OP_COPY, F_IALU, 1'b1);
  endtask

  // drive one instruction, gaps hold i_stalled high or i_en_dec low
  task automatic send_entry(input int e);
    expect_t     ex;
    nibble_t     nib;
    logic [31:0] rnd;
    int          gaps;
    int          pos;
    ex = '0;
    ex.idx = e;
    // now and then a taken branch moves the PC
    rnd = next_rand();
    if (rnd[1:0] == 2'b00) begin
      pc = rnd[31:12];
    end
    for (int k = 0; k < tbl_len[e]; k++) begin
      gaps = tbl_stall[e] ? int'(next_rand() % 4) : 0;
      repeat (gaps) begin
        @(negedge i_clk);
        rnd       = next_rand();
        i_stalled = rnd[4];
        i_en_dec  = rnd[4] ? rnd[5] : 1'b0;
        i_nibble  = rnd[11:8];
        i_pc      = rnd[31:12];
      end
      rnd = next_rand();
      if (k == 0) begin
        nib = tbl_n0[e];
      end else if (k == 1 && tbl_fixed[e] == 2) begin
        nib = tbl_n1[e];
      end else begin
        nib = rnd[3:0];
      end
      @(negedge i_clk);
      i_en_dec  = 1'b1;
      i_stalled = 1'b0;
      i_nibble  = nib;
      i_pc      = pc;
      if (k == 0) begin
        ex.addr = pc;
      end
      pc = pc + 1'b1;
      // immediates are the trailing nibbles, low position first
      pos = k - (tbl_len[e] - tbl_nimm[e]);
      if (pos >= 0) begin
        ex.load[pos*NIBBLE_W +: NIBBLE_W] = nib;
        ex.imm = nib;
      end
      if (k == tbl_len[e] - 1) begin
        ex.cycle = cycle_cnt + 2;
        exp_q.push_back(ex);
      end
    end
  endtask

  task automatic check_decode(input expect_t ex);
    if (ex.cycle != cycle_cnt) begin
      report_error($sformatf("entry %0d decoded in cycle %0d, expected %0d",
                             ex.idx, cycle_cnt, ex.cycle));
    end
    if (o_alu_op != tbl_alu[ex.idx]) begin
      report_error($sformatf("entry %0d alu_op got %0d exp %0d",
                             ex.idx, o_alu_op, tbl_alu[ex.idx]));
    end
    if (got_flags != tbl_flags[ex.idx]) begin
      report_error($sformatf("entry %0d fields got %h exp %h",
                             ex.idx, got_flags, tbl_flags[ex.idx]));
    end
    if (o_ins_addr != ex.addr) begin
      report_error($sformatf("entry %0d addr got %h exp %h", ex.idx, o_ins_addr, ex.addr));
    end
    if (o_mem_pos != POS_W'(tbl_nimm[ex.idx])) begin
      report_error($sformatf("entry %0d mem_pos got %0d exp %0d",
                             ex.idx, o_mem_pos, tbl_nimm[ex.idx]));
    end
    if (o_mem_load != ex.load) begin
      report_error($sformatf("entry %0d mem_load got %h exp %h", ex.idx, o_mem_load, ex.load));
    end
    if (tbl_nimm[ex.idx] != 0 && o_imm_value != ex.imm) begin
      report_error($sformatf("entry %0d imm_value got %h exp %h", ex.idx, o_imm_value, ex.imm));
    end
    held_alu   = tbl_alu[ex.idx];
    held_flags = tbl_flags[ex.idx];
  endtask

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // cycle count and check enable change on the rising edge only
  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    check_en  <= !i_reset;
  end

  // monitor on the falling edge
  always @(negedge i_clk) begin
    if (check_en) begin
      if (o_ins_decoded) begin
        decode_cnt++;
        if (exp_q.size() == 0) begin
          report_error("decode pulse with no instruction in flight");
        end else begin
          mon_ex = exp_q.pop_front();
          check_decode(mon_ex);
        end
      end else begin
        if (exp_q.size() != 0 && exp_q[0].cycle <= cycle_cnt) begin
          report_error($sformatf("entry %0d gave no decode pulse", exp_q[0].idx));
          exp_q.delete(0);
        end
        if (got_flags != held_flags || o_alu_op != held_alu) begin
          report_error("decoded fields changed without a decode pulse");
        end
      end
    end
  end

  initial begin
    int limit;
    i_reset   = 1'b1;
    i_en_dec  = 1'b0;
    i_stalled = 1'b0;
    i_nibble  = '0;
    i_pc      = '0;
    pc        = ADDR_W'('h4000);
    build_table();
    // worst case stall is 3 gap cycles per nibble
    limit = 20;
    for (int e = 0; e < tbl_len.size(); e++) begin
      limit += tbl_len[e] * (tbl_stall[e] ? 4 : 1);
    end
    fork
      begin
        #(limit * 10 * 4);
        $display("watchdog: run timed out, %0d instructions never decoded", exp_q.size());
        $display("RESULT: FAIL");
        $finish;
      end
    join_none
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    if (o_ins_decoded || o_mem_pos != '0 || o_alu_op != ALU_OP_NONE || got_flags != '0) begin
      report_error("outputs not at their reset values");
    end
    // back to back unless the row asks for stalls
    for (int e = 0; e < tbl_len.size(); e++) begin
      send_entry(e);
    end
    @(negedge i_clk);
    i_en_dec = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
    // quiet tail, any pulse here is unexpected
    repeat (8) @(negedge i_clk);
    if (decode_cnt != tbl_len.size()) begin
      report_error($sformatf("%0d decode pulses for %0d instructions",
                             decode_cnt, tbl_len.size()));
    end
    $display("errors: %0d, decodes: %0d of %0d", err_cnt, decode_cnt, tbl_len.size());
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: saturn_decoder.f
hw/saturn_dec_pkg.sv
hw/opcode_classifier.sv
hw/instruction_assembler.sv
hw/saturn_decoder.sv
dv/saturn_decoder_sva.sv
dv/saturn_decoder_tb.sv

// File: Makefile
TOP = saturn_decoder_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f saturn_decoder.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

lint:
	verilator --lint-only -Wall --top-module saturn_decoder \
	  hw/saturn_dec_pkg.sv hw/opcode_classifier.sv hw/instruction_assembler.sv hw/saturn_decoder.sv

clean:
	rm -rf obj_dir
